// File: Makefile
TOP = tb_icache_lookup

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

obj_dir/V$(TOP): tb.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

// File: rtl/icache_data_store.sv
// Line data array of all sets. Refill writes own the single port, lookups
// read one cycle ahead of the output and the read register can be frozen.

`timescale 1ns/1ps

module icache_data_store import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       init_i,
  // Refill port
  input  logic       write_valid_i,
  input  set_t       write_set_i,
  input  index_t     write_addr_i,
  input  line_t      write_data_i,
  // Lookup port
  input  data_addr_t lookup_addr_i,
  input  logic       read_en_i,
  input  logic       data_hold_i,
  output line_t      rdata_o
);

  line_t      line_mem [SET_COUNT * LINE_COUNT];
  line_t      rdata_q;
  logic       write_en;
  logic       read_en;
  data_addr_t write_addr;

  // --------------------------------------------------------------------------
  // Port arbitration
  // --------------------------------------------------------------------------

  // Refills are not accepted while the tags are being cleared
  assign write_en   = write_valid_i && !init_i;
  assign write_addr = {write_set_i, write_addr_i};

  // A blocked output keeps the line it already read
  assign read_en = read_en_i && !write_en && !data_hold_i;

  // --------------------------------------------------------------------------
  // Array and read register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (write_en) begin
      line_mem[write_addr] <= write_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_en) begin
      rdata_q <= line_mem[lookup_addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/icache_lookup_top.sv
// Instruction cache lookup pipeline. Connects the tag stage, the data store
// and the output stage to the fetch, refill and flush ports.

`timescale 1ns/1ps

module icache_lookup_top import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Flush
  input  logic   flush_valid_i,
  output logic   flush_ready_o,
  // Fetch request
  input  addr_t  in_addr_i,
  input  id_t    in_id_i,
  input  logic   in_valid_i,
  output logic   in_ready_o,
  // Lookup result
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output set_t   out_set_o,
  output logic   out_hit_o,
  output line_t  out_data_o,
  output logic   out_error_o,
  output logic   out_valid_o,
  input  logic   out_ready_i,
  // Refill
  input  index_t write_addr_i,
  input  set_t   write_set_i,
  input  tag_t   write_tag_i,
  input  line_t  write_data_i,
  input  logic   write_error_i,
  input  logic   write_valid_i,
  output logic   write_ready_o
);

  logic       tag_valid;
  logic       tag_ready;
  addr_t      req_addr;
  id_t        req_id;
  logic       tag_hit;
  set_t       tag_set;
  logic       tag_error;
  data_addr_t lookup_addr;
  logic       read_en;
  logic       init;
  line_t      rdata;
  logic       data_hold;

  icache_tag_stage u_tag_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .in_addr_i     (in_addr_i),
    .in_id_i       (in_id_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .write_addr_i  (write_addr_i),
    .write_set_i   (write_set_i),
    .write_tag_i   (write_tag_i),
    .write_error_i (write_error_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .tag_ready_i   (tag_ready),
    .tag_valid_o   (tag_valid),
    .req_addr_o    (req_addr),
    .req_id_o      (req_id),
    .hit_o         (tag_hit),
    .set_o         (tag_set),
    .error_o       (tag_error),
    .lookup_addr_o (lookup_addr),
    .read_en_o     (read_en),
    .init_o        (init)
  );

  icache_data_store u_data_store (
    .clk_i         (clk_i),
    .init_i        (init),
    .write_valid_i (write_valid_i),
    .write_set_i   (write_set_i),
    .write_addr_i  (write_addr_i),
    .write_data_i  (write_data_i),
    .lookup_addr_i (lookup_addr),
    .read_en_i     (read_en),
    .data_hold_i   (data_hold),
    .rdata_o       (rdata)
  );

  icache_output_stage u_output_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tag_valid_i   (tag_valid),
    .tag_ready_o   (tag_ready),
    .req_addr_i    (req_addr),
    .req_id_i      (req_id),
    .hit_i         (tag_hit),
    .set_i         (tag_set),
    .error_i       (tag_error),
    .write_valid_i (write_valid_i),
    .write_addr_i  (write_addr_i),
    .write_set_i   (write_set_i),
    .write_tag_i   (write_tag_i),
    .write_data_i  (write_data_i),
    .write_error_i (write_error_i),
    .rdata_i       (rdata),
    .data_hold_o   (data_hold),
    .out_addr_o    (out_addr_o),
    .out_id_o      (out_id_o),
    .out_set_o     (out_set_o),
    .out_hit_o     (out_hit_o),
    .out_data_o    (out_data_o),
    .out_error_o   (out_error_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

// File: rtl/icache_output_stage.sv
// Last lookup stage. Registers the tag result, merges in the line read from
// the data store and substitutes refill data when a refill hits the request.

`timescale 1ns/1ps

module icache_output_stage import icache_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // From the tag stage
  input  logic   tag_valid_i,
  output logic   tag_ready_o,
  input  addr_t  req_addr_i,
  input  id_t    req_id_i,
  input  logic   hit_i,
  input  set_t   set_i,
  input  logic   error_i,
  // Refill port, observed for the bypass
  input  logic   write_valid_i,
  input  index_t write_addr_i,
  input  set_t   write_set_i,
  input  tag_t   write_tag_i,
  input  line_t  write_data_i,
  input  logic   write_error_i,
  // Data store
  input  line_t  rdata_i,
  output logic   data_hold_o,
  // Response
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output set_t   out_set_o,
  output logic   out_hit_o,
  output line_t  out_data_o,
  output logic   out_error_o,
  output logic   out_valid_o,
  input  logic   out_ready_i
);

  logic  bypass;
  logic  handover;
  logic  out_valid_q;
  logic  bypass_q;
  addr_t addr_q;
  id_t   id_q;
  logic  hit_q;
  set_t  set_q;
  logic  error_q;
  line_t refill_data_q;
  set_t  refill_set_q;
  logic  refill_error_q;

  // --------------------------------------------------------------------------
  // Bypass detection and handshake
  // --------------------------------------------------------------------------

  // Refill carries exactly the line the request in flight is looking for
  assign bypass = tag_valid_i && write_valid_i &&
                  (write_tag_i == req_addr_i[FETCH_AW-1 -: TAG_WIDTH]) &&
                  (write_addr_i == req_addr_i[LINE_ALIGN +: COUNT_ALIGN]);

  // Any other refill owns the data port, so the tag entry waits
  assign tag_ready_o = (!out_valid_q || out_ready_i) && (!write_valid_i || bypass);
  assign handover    = tag_valid_i && tag_ready_o;
  assign data_hold_o = out_valid_q && !out_ready_i;

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      bypass_q    <= 1'b0;
    end else begin
      out_valid_q <= handover ? 1'b1 : (out_ready_i ? 1'b0 : out_valid_q);
      if (handover) begin
        bypass_q <= bypass;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (handover) begin
      addr_q  <= req_addr_i;
      id_q    <= req_id_i;
      hit_q   <= hit_i;
      set_q   <= set_i;
      error_q <= error_i;
    end
    if (handover && bypass) begin
      refill_data_q  <= write_data_i;
      refill_set_q   <= write_set_i;
      refill_error_q <= write_error_i;
    end
  end

  assign out_addr_o  = addr_q;
  assign out_id_o    = id_q;
  assign out_hit_o   = bypass_q || hit_q;
  assign out_set_o   = bypass_q ? refill_set_q : set_q;
  assign out_error_o = bypass_q ? refill_error_q : error_q;
  assign out_data_o  = bypass_q ? refill_data_q : rdata_i;
  assign out_valid_o = out_valid_q;

endmodule

// File: rtl/icache_pkg.sv
// Shared geometry, field types and tag port operations of the instruction
// cache lookup pipeline. Every RTL block imports this package.

package icache_pkg;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int unsigned FETCH_AW    = 32;
  localparam int unsigned ID_WIDTH    = 4;
  localparam int unsigned LINE_WIDTH  = 64;
  localparam int unsigned LINE_ALIGN  = 3;
  localparam int unsigned LINE_COUNT  = 16;
  localparam int unsigned COUNT_ALIGN = 4;
  localparam int unsigned SET_COUNT   = 2;
  localparam int unsigned SET_ALIGN   = 1;

  // Address bits left above the byte offset and the line index
  localparam int unsigned TAG_WIDTH = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;

  // --------------------------------------------------------------------------
  // Field types
  // --------------------------------------------------------------------------
  typedef logic [FETCH_AW-1:0]    addr_t;
  typedef logic [ID_WIDTH-1:0]    id_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [COUNT_ALIGN-1:0] index_t;
  typedef logic [SET_ALIGN-1:0]   set_t;

  // Data array address, set number on top of the line index
  typedef logic [SET_ALIGN+COUNT_ALIGN-1:0] data_addr_t;

  // Operation on the shared tag port in a given cycle
  typedef enum logic [1:0] {
    TAG_INIT,
    TAG_WRITE,
    TAG_READ,
    TAG_IDLE
  } tag_port_op_e;

endpackage

// File: rtl/icache_tag_stage.sv
// First lookup stage. Runs the init/flush walk, arbitrates the tag port,
// keeps the tag arrays and compares the registered request against all sets.

`timescale 1ns/1ps

module icache_tag_stage import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_valid_i,
  output logic       flush_ready_o,
  input  addr_t      in_addr_i,
  input  id_t        in_id_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  index_t     write_addr_i,
  input  set_t       write_set_i,
  input  tag_t       write_tag_i,
  input  logic       write_error_i,
  input  logic       write_valid_i,
  output logic       write_ready_o,
  input  logic       tag_ready_i,
  output logic       tag_valid_o,
  output addr_t      req_addr_o,
  output id_t        req_id_o,
  output logic       hit_o,
  output set_t       set_o,
  output logic       error_o,
  output data_addr_t lookup_addr_o,
  output logic       read_en_o,
  output logic       init_o
);

  logic [COUNT_ALIGN:0]   init_count_q;
  tag_port_op_e           tag_op;
  index_t                 tag_addr;
  logic [SET_COUNT-1:0]   tag_we;
  logic                   tag_wvalid;
  logic                   tag_werror;
  tag_t                   tag_wtag;
  logic                   valid_mem [SET_COUNT][LINE_COUNT];
  logic                   error_mem [SET_COUNT][LINE_COUNT];
  tag_t                   tag_mem   [SET_COUNT][LINE_COUNT];
  logic                   rd_valid_q [SET_COUNT];
  logic                   rd_error_q [SET_COUNT];
  tag_t                   rd_tag_q   [SET_COUNT];
  logic                   accept;
  logic                   tag_valid_q;
  logic                   req_handshake_q;
  addr_t                  req_addr_q;
  id_t                    req_id_q;
  logic [SET_COUNT-1:0]   line_hit;
  logic [SET_COUNT-1:0]   line_err;
  logic                   hit_s, hit_d, hit_q;
  set_t                   set_s, set_d, set_q;
  logic                   error_s, error_d, error_q;

  // --------------------------------------------------------------------------
  // Init walk, restarted by every flush pulse
  // --------------------------------------------------------------------------
  assign flush_ready_o = 1'b1;
  assign init_o        = init_count_q != (COUNT_ALIGN+1)'(LINE_COUNT);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_count_q <= '0;
    end else if (init_o) begin
      init_count_q <= init_count_q + 1'b1;
    end else if (flush_valid_i) begin
      init_count_q <= '0;
    end
  end

  // --------------------------------------------------------------------------
  // Tag port arbitration: init, then refill, then lookup
  // --------------------------------------------------------------------------
  always_comb begin
    tag_op = TAG_IDLE;
    if (init_o) begin
      tag_op = TAG_INIT;
    end else if (write_valid_i) begin
      tag_op = TAG_WRITE;
    end else if (in_valid_i) begin
      tag_op = TAG_READ;
    end
  end

  always_comb begin
    tag_addr   = in_addr_i[LINE_ALIGN +: COUNT_ALIGN];
    tag_we     = '0;
    tag_wvalid = 1'b1;
    tag_werror = write_error_i;
    tag_wtag   = write_tag_i;
    case (tag_op)
      TAG_INIT: begin
        tag_addr   = init_count_q[COUNT_ALIGN-1:0];
        tag_we     = '1;
        tag_wvalid = 1'b0;
        tag_werror = 1'b0;
        tag_wtag   = '0;
      end
      TAG_WRITE: begin
        tag_addr = write_addr_i;
        tag_we   = SET_COUNT'(1) << write_set_i;
      end
      default: ;
    endcase
  end

  assign write_ready_o = !init_o;
  assign in_ready_o    = (tag_op == TAG_READ) && (!tag_valid_q || tag_ready_i);
  assign accept        = in_valid_i && in_ready_o;

  // Tag arrays, one-cycle synchronous read
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < SET_COUNT; s++) begin
      if (tag_we[s]) begin
        valid_mem[s][tag_addr] <= tag_wvalid;
        error_mem[s][tag_addr] <= tag_werror;
        tag_mem[s][tag_addr]   <= tag_wtag;
      end else if (tag_op == TAG_READ) begin
        rd_valid_q[s] <= valid_mem[s][tag_addr];
        rd_error_q[s] <= error_mem[s][tag_addr];
        rd_tag_q[s]   <= tag_mem[s][tag_addr];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Request register and tag compare
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= in_addr_i;
      req_id_q   <= in_id_i;
    end
  end

  always_comb begin
    set_s = '0;
    for (int s = 0; s < SET_COUNT; s++) begin
      line_hit[s] = rd_valid_q[s] && (rd_tag_q[s] == req_addr_q[FETCH_AW-1 -: TAG_WIDTH]);
      line_err[s] = rd_error_q[s] && line_hit[s];
    end
    // Descending scan so the lowest matching set is the one kept
    for (int s = SET_COUNT - 1; s >= 0; s--) begin
      if (line_hit[s]) begin
        set_s = set_t'(s);
      end
    end
    hit_s   = |line_hit;
    error_s = |line_err;
  end

  // Compare result is fresh right after a read, otherwise replayed from the holding register
  assign hit_o   = req_handshake_q ? hit_s : hit_q;
  assign set_o   = req_handshake_q ? set_s : set_q;
  assign error_o = req_handshake_q ? error_s : error_q;

  assign lookup_addr_o = {set_o, req_addr_q[LINE_ALIGN +: COUNT_ALIGN]};
  assign read_en_o     = tag_valid_q && hit_o;

  always_comb begin
    hit_d   = hit_q;
    set_d   = set_q;
    error_d = error_q;
    if (req_handshake_q && !tag_ready_i) begin
      hit_d   = hit_s;
      set_d   = set_s;
      error_d = error_s;
    end
    // A refill into the line we hit replaces its data, so the held hit is stale
    if (write_valid_i && write_ready_o && (lookup_addr_o == {write_set_i, write_addr_i})) begin
      hit_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_valid_q     <= 1'b0;
      req_handshake_q <= 1'b0;
      hit_q           <= 1'b0;
      set_q           <= '0;
      error_q         <= 1'b0;
    end else begin
      tag_valid_q     <= accept ? 1'b1 : (tag_ready_i ? 1'b0 : tag_valid_q);
      req_handshake_q <= accept;
      hit_q           <= hit_d;
      set_q           <= set_d;
      error_q         <= error_d;
    end
  end

  assign tag_valid_o = tag_valid_q;
  assign req_addr_o  = req_addr_q;
  assign req_id_o    = req_id_q;

endmodule

// File: tb.f
rtl/icache_pkg.sv
rtl/icache_tag_stage.sv
rtl/icache_data_store.sv
rtl/icache_output_stage.sv
rtl/icache_lookup_top.sv
verif/tb_icache_lookup.sv

// File: verif/tb_icache_lookup.sv
// Directed testbench of the instruction cache lookup pipeline. Runs init,
// refill, two-set, flush, bypass and back-pressure tests against a line model.

`timescale 1ns/1ps

module tb_icache_lookup import icache_pkg::*; ();

  localparam int unsigned WAIT_LIMIT = 64;

  logic   clk_i;
  logic   rst_ni;
  logic   flush_valid_i;
  logic   flush_ready_o;
  addr_t  in_addr_i;
  id_t    in_id_i;
  logic   in_valid_i;
  logic   in_ready_o;
  addr_t  out_addr_o;
  id_t    out_id_o;
  set_t   out_set_o;
  logic   out_hit_o;
  line_t  out_data_o;
  logic   out_error_o;
  logic   out_valid_o;
  logic   out_ready_i;
  index_t write_addr_i;
  set_t   write_set_i;
  tag_t   write_tag_i;
  line_t  write_data_i;
  logic   write_error_i;
  logic   write_valid_i;
  logic   write_ready_o;

  // Reference model of the cache contents
  logic        model_valid [SET_COUNT][LINE_COUNT];
  logic        model_error [SET_COUNT][LINE_COUNT];
  tag_t        model_tag   [SET_COUNT][LINE_COUNT];
  line_t       model_data  [SET_COUNT][LINE_COUNT];
  addr_t       filled_q [$];
  logic [31:0] rng_state;
  int unsigned errors;
  int unsigned checks;

  icache_lookup_top u_dut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic addr_t make_addr(tag_t tag, index_t idx);
    return {tag, idx, {LINE_ALIGN{1'b0}}};
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_line(line_t got, line_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(addr_t got, addr_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_id(id_t got, id_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_set(set_t got, set_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus tasks start and end on a falling edge
  // --------------------------------------------------------------------------
  task automatic send_lookup(addr_t addr, id_t id);
    int unsigned cycles;
    cycles     = 0;
    in_addr_i  = addr;
    in_id_i    = id;
    in_valid_i = 1'b1;
    #1;
    while (!in_ready_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!in_ready_o) begin
      errors++;
      $display("ERROR: timeout, lookup of %h was never accepted", addr);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic drive_refill(index_t idx, set_t set, tag_t tag, line_t data, logic err);
    int unsigned cycles;
    cycles        = 0;
    write_addr_i  = idx;
    write_set_i   = set;
    write_tag_i   = tag;
    write_data_i  = data;
    write_error_i = err;
    write_valid_i = 1'b1;
    model_valid[set][idx] = 1'b1;
    model_error[set][idx] = err;
    model_tag[set][idx]   = tag;
    model_data[set][idx]  = data;
    filled_q.push_back(make_addr(tag, idx));
    #1;
    while (!write_ready_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!write_ready_o) begin
      errors++;
      $display("ERROR: timeout, refill of index %h was never accepted", idx);
    end
    @(negedge clk_i);
    write_valid_i = 1'b0;
  endtask

  // Expected result from the model where the lowest matching set wins
  task automatic predict(addr_t addr, output logic hit, output set_t set,
                         output logic err, output line_t data);
    index_t idx;
    idx  = addr[LINE_ALIGN +: COUNT_ALIGN];
    hit  = 1'b0;
    set  = '0;
    err  = 1'b0;
    data = '0;
    for (int s = 0; s < SET_COUNT; s++) begin
      if (!hit && model_valid[s][idx] && model_tag[s][idx] == addr[FETCH_AW-1 -: TAG_WIDTH]) begin
        hit  = 1'b1;
        set  = set_t'(s);
        err  = model_error[s][idx];
        data = model_data[s][idx];
      end
    end
  endtask

  task automatic expect_result(addr_t addr, id_t id);
    int unsigned cycles;
    logic        exp_hit;
    set_t        exp_set;
    logic        exp_err;
    line_t       exp_data;
    cycles = 0;
    predict(addr, exp_hit, exp_set, exp_err, exp_data);
    while (!out_valid_o && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!out_valid_o) begin
      errors++;
      $display("ERROR: timeout, no result arrived for lookup of %h", addr);
    end else begin
      check_addr(out_addr_o, addr, "out_addr_o");
      check_id(out_id_o, id, "out_id_o");
      check_bit(out_hit_o, exp_hit, "out_hit_o");
      check_bit(out_error_o, exp_err, "out_error_o");
      if (exp_hit) begin
        check_set(out_set_o, exp_set, "out_set_o");
        check_line(out_data_o, exp_data, "out_data_o");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic lookup_check(addr_t addr, id_t id);
    send_lookup(addr, id);
    expect_result(addr, id);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic init_lookups_miss();
    check_bit(write_ready_o, 1'b0, "write_ready_o during init");
    check_bit(out_valid_o, 1'b0, "out_valid_o after reset");
    for (int i = 0; i < LINE_COUNT; i++) begin
      lookup_check(make_addr(tag_t'(next_random()), index_t'(i)), id_t'(i));
    end
    check_bit(write_ready_o, 1'b1, "write_ready_o after init");
  endtask

  task automatic refill_then_hit();
    tag_t   tag;
    index_t idx;
    for (int i = 0; i < 4; i++) begin
      tag = tag_t'(next_random());
      idx = index_t'(next_random());
      drive_refill(idx, set_t'(i), tag, {next_random(), next_random()}, 1'b0);
      lookup_check(make_addr(tag, idx), id_t'(i + 1));
    end
  endtask

  task automatic two_sets_and_error();
    tag_t   tag_a;
    tag_t   tag_b;
    index_t idx;
    tag_a = tag_t'(next_random());
    tag_b = tag_a ^ tag_t'(1);
    idx   = index_t'(next_random());
    drive_refill(idx, 1'b0, tag_a, {next_random(), next_random()}, 1'b0);
    drive_refill(idx, 1'b1, tag_b, {next_random(), next_random()}, 1'b1);
    lookup_check(make_addr(tag_a, idx), 4'h5);
    lookup_check(make_addr(tag_b, idx), 4'h6);
  endtask

  task automatic flush_clears_lines();
    check_bit(flush_ready_o, 1'b1, "flush_ready_o");
    flush_valid_i = 1'b1;
    @(negedge clk_i);
    flush_valid_i = 1'b0;
    for (int s = 0; s < SET_COUNT; s++) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        model_valid[s][i] = 1'b0;
      end
    end
    while (filled_q.size() > 0) begin
      lookup_check(filled_q.pop_front(), 4'h7);
    end
  endtask

  task automatic refill_bypass();
    tag_t   tag;
    index_t idx;
    tag = tag_t'(next_random());
    idx = index_t'(next_random());
    // Refill lands one cycle after the lookup was accepted
    send_lookup(make_addr(tag, idx), 4'h9);
    drive_refill(idx, 1'b1, tag, {next_random(), next_random()}, 1'b1);
    expect_result(make_addr(tag, idx), 4'h9);
    lookup_check(make_addr(tag, idx), 4'h8);
  endtask

  task automatic backpressure_in_order();
    addr_t addr [3];
    logic  exp_hit;
    set_t  exp_set;
    logic  exp_err;
    line_t exp_data;
    for (int i = 0; i < 3; i++) begin
      addr[i] = make_addr(tag_t'(next_random()), index_t'(i * 5));
      // The third line stays empty and gives a miss
      if (i < 2) begin
        drive_refill(index_t'(i * 5), set_t'(i), addr[i][FETCH_AW-1 -: TAG_WIDTH],
                     {next_random(), next_random()}, 1'b0);
      end
    end
    predict(addr[0], exp_hit, exp_set, exp_err, exp_data);
    out_ready_i = 1'b0;
    send_lookup(addr[0], 4'ha);
    send_lookup(addr[1], 4'hb);
    fork
      send_lookup(addr[2], 4'hc);
      begin
        repeat (6) begin
          @(negedge clk_i);
          #1;
          check_bit(out_valid_o, 1'b1, "out_valid_o while blocked");
          check_addr(out_addr_o, addr[0], "out_addr_o while blocked");
          check_id(out_id_o, 4'ha, "out_id_o while blocked");
          check_bit(out_hit_o, exp_hit, "out_hit_o while blocked");
          check_set(out_set_o, exp_set, "out_set_o while blocked");
          check_bit(out_error_o, exp_err, "out_error_o while blocked");
          check_line(out_data_o, exp_data, "out_data_o while blocked");
          check_bit(in_ready_o, 1'b0, "in_ready_o while blocked");
        end
        @(negedge clk_i);
        out_ready_i = 1'b1;
        expect_result(addr[0], 4'ha);
        expect_result(addr[1], 4'hb);
        expect_result(addr[2], 4'hc);
      end
    join
    check_bit(out_valid_o, 1'b0, "out_valid_o after drain");
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    flush_valid_i = 1'b0;
    in_addr_i     = '0;
    in_id_i       = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    write_addr_i  = '0;
    write_set_i   = '0;
    write_tag_i   = '0;
    write_data_i  = '0;
    write_error_i = 1'b0;
    write_valid_i = 1'b0;
    rng_state     = 32'hd76567e9;
    errors        = 0;
    checks        = 0;
    for (int s = 0; s < SET_COUNT; s++) begin
      for (int i = 0; i < LINE_COUNT; i++) begin
        model_valid[s][i] = 1'b0;
      end
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    init_lookups_miss();
    refill_then_hit();
    two_sets_and_error();
    flush_clears_lines();
    refill_bypass();
    backpressure_in_order();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
